/* logic/timer_bank_pkg.sv */
// Shared widths, address map and register offsets of the timer bank.
// Modules import it in their bodies and use scoped names in their headers.

package timer_bank_pkg;

	// --------------------------------------------------
	// bus and bank sizing
	localparam int N_CHANNELS = 4;
	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 32;

	// --------------------------------------------------
	// address map
	// each channel owns a 4 KiB window selected by the slot field
	localparam int SLOT_LSB = 12;
	localparam int SLOT_W   = 2;
	// any set bit from here up is outside the bank
	localparam int MAP_LSB  = SLOT_LSB + SLOT_W;
	// word offset inside one slot
	localparam int OFFSET_W = SLOT_LSB - 2;

	// byte offsets of the channel registers
	localparam logic [SLOT_LSB-1:0] REG_CTRL     = 12'h000;
	localparam logic [SLOT_LSB-1:0] REG_MTIME    = 12'h004;
	localparam logic [SLOT_LSB-1:0] REG_MTIMECMP = 12'h008;

	// control register fields
	localparam int CTRL_EN_BIT  = 0;
	localparam int CTRL_IRQ_BIT = 1;

	// --------------------------------------------------
	// timebase
	localparam int TICK_DIV = 5;
	localparam int TICK_W   = $clog2(TICK_DIV);

	// cycles a bus master waits for pready before giving up
	localparam int APB_TIMEOUT = 16;

	typedef logic [ADDR_W-1:0]     paddr_t;
	typedef logic [DATA_W-1:0]     pdata_t;
	typedef logic [N_CHANNELS-1:0] chan_vec_t;
	typedef logic [OFFSET_W-1:0]   offset_t;

endpackage

/* logic/tick_prescaler.sv */
// Timebase for the channel timers.
// Produces a one-cycle tick every TICK_DIV clock cycles after reset.

`timescale 1ns/100ps

module tick_prescaler (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	import timer_bank_pkg::*;

	logic [TICK_W-1:0] count;

	// down-counter, reloads when it hits zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			tick  <= 1'b0;
		end else begin
			if (|count) begin
				count <= count - 1'b1;
			end else begin
				count <= TICK_W'(TICK_DIV - 1);
			end
			// one cycle after the count passes zero
			tick <= ~|count;
		end
	end

endmodule

/* logic/apb_slot_decoder.sv */
// Splits the APB address into a channel select and an in-slot word offset.
// The access itself is broadcast unchanged to every channel.

`timescale 1ns/100ps

module apb_slot_decoder (
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  timer_bank_pkg::paddr_t     paddr,
	input  timer_bank_pkg::pdata_t     pwdata,
	output timer_bank_pkg::chan_vec_t  psel_ch,
	output logic                       penable_ch,
	output logic                       pwrite_ch,
	output timer_bank_pkg::offset_t    offset,
	output timer_bank_pkg::pdata_t     pwdata_ch
);

	import timer_bank_pkg::*;

	logic              unmapped;
	logic [SLOT_W-1:0] slot;

	// --------------------------------------------------
	// address split
	assign unmapped = |paddr[ADDR_W-1:MAP_LSB];
	assign slot     = paddr[MAP_LSB-1:SLOT_LSB];
	// byte lanes are ignored, registers are whole words
	assign offset   = paddr[SLOT_LSB-1:2];

	// at most one select, and only for a populated slot
	always_comb begin
		psel_ch = '0;
		if (psel && !unmapped && (int'(slot) < N_CHANNELS)) begin
			psel_ch[slot] = 1'b1;
		end
	end

	// --------------------------------------------------
	// broadcast to all channels
	assign penable_ch = penable;
	assign pwrite_ch  = pwrite;
	assign pwdata_ch  = pwdata;

endmodule

/* logic/timer_channel.sv */
// One machine timer channel behind an APB slave port.
// Holds control, mtime and mtimecmp and raises irq when mtime >= mtimecmp.

`timescale 1ns/100ps

module timer_channel (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    tick,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  timer_bank_pkg::offset_t offset,
	input  timer_bank_pkg::pdata_t  pwdata,
	output timer_bank_pkg::pdata_t  prdata,
	output logic                    pslverr,
	output logic                    irq
);

	import timer_bank_pkg::*;

	logic   enable;
	pdata_t mtime;
	pdata_t mtimecmp;

	logic access;
	logic hit_ctrl;
	logic hit_mtime;
	logic hit_mtimecmp;
	logic known;

	// --------------------------------------------------
	// register decode
	assign access       = psel && penable;
	assign hit_ctrl     = (offset == REG_CTRL[SLOT_LSB-1:2]);
	assign hit_mtime    = (offset == REG_MTIME[SLOT_LSB-1:2]);
	assign hit_mtimecmp = (offset == REG_MTIMECMP[SLOT_LSB-1:2]);
	assign known        = hit_ctrl || hit_mtime || hit_mtimecmp;

	// unknown offsets answer with an error and write nothing
	assign pslverr = access && !known;

	// --------------------------------------------------
	// control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable <= 1'b0;
		end else if (access && pwrite && hit_ctrl) begin
			enable <= pwdata[CTRL_EN_BIT];
		end
	end

	// --------------------------------------------------
	// mtime counter
	// a bus write wins over the tick increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (access && pwrite && hit_mtime) begin
			mtime <= pwdata;
		end else if (tick && enable) begin
			mtime <= mtime + 1'b1;
		end
	end

	// --------------------------------------------------
	// compare value, all ones keeps irq quiet out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else if (access && pwrite && hit_mtimecmp) begin
			mtimecmp <= pwdata;
		end
	end

	assign irq = enable && (mtime >= mtimecmp);

	// --------------------------------------------------
	// read back
	always_comb begin
		prdata = '0;
		if (hit_ctrl) begin
			prdata[CTRL_EN_BIT]  = enable;
			prdata[CTRL_IRQ_BIT] = irq;
		end else if (hit_mtime) begin
			prdata = mtime;
		end else if (hit_mtimecmp) begin
			prdata = mtimecmp;
		end
	end

endmodule

/* logic/apb_response_mux.sv */
// Collects the APB response of the selected channel.
// Accesses that select no channel are answered with an error and zero data.

`timescale 1ns/100ps

module apb_response_mux (
	input  logic                      psel,
	input  logic                      penable,
	input  timer_bank_pkg::chan_vec_t psel_ch,
	input  timer_bank_pkg::pdata_t    prdata_ch [timer_bank_pkg::N_CHANNELS],
	input  timer_bank_pkg::chan_vec_t pslverr_ch,
	output timer_bank_pkg::pdata_t    prdata,
	output logic                      pready,
	output logic                      pslverr
);

	import timer_bank_pkg::*;

	logic access;
	logic any_sel;

	assign access  = psel && penable;
	assign any_sel = |psel_ch;

	// no wait states, every access cycle completes
	assign pready = access;

	// select is one-hot, so an OR over the masked inputs is enough
	always_comb begin
		prdata = '0;
		for (int i = 0; i < N_CHANNELS; i++) begin
			if (psel_ch[i]) begin
				prdata = prdata | prdata_ch[i];
			end
		end
	end

	// unmapped address gets an error from here
	always_comb begin
		if (!access) begin
			pslverr = 1'b0;
		end else if (any_sel) begin
			pslverr = |(psel_ch & pslverr_ch);
		end else begin
			pslverr = 1'b1;
		end
	end

endmodule

/* logic/timer_bank.sv */
// Top of the timer bank: an APB slave in front of N_CHANNELS machine timers.
// One compare interrupt per channel comes out on irq.

`timescale 1ns/100ps

module timer_bank (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  timer_bank_pkg::paddr_t    paddr,
	input  timer_bank_pkg::pdata_t    pwdata,
	output timer_bank_pkg::pdata_t    prdata,
	output logic                      pready,
	output logic                      pslverr,
	output timer_bank_pkg::chan_vec_t irq
);

	import timer_bank_pkg::*;

	logic      tick;
	chan_vec_t psel_ch;
	logic      penable_ch;
	logic      pwrite_ch;
	offset_t   offset;
	pdata_t    pwdata_ch;
	pdata_t    prdata_ch [N_CHANNELS];
	chan_vec_t pslverr_ch;

	// --------------------------------------------------
	// timebase
	tick_prescaler u_prescaler (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	// --------------------------------------------------
	// address split
	apb_slot_decoder u_decoder (
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.psel_ch    (psel_ch),
		.penable_ch (penable_ch),
		.pwrite_ch  (pwrite_ch),
		.offset     (offset),
		.pwdata_ch  (pwdata_ch)
	);

	// --------------------------------------------------
	// channels
	for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan
		timer_channel u_channel (
			.clk     (clk),
			.rst_n   (rst_n),
			.tick    (tick),
			.psel    (psel_ch[i]),
			.penable (penable_ch),
			.pwrite  (pwrite_ch),
			.offset  (offset),
			.pwdata  (pwdata_ch),
			.prdata  (prdata_ch[i]),
			.pslverr (pslverr_ch[i]),
			.irq     (irq[i])
		);
	end

	// --------------------------------------------------
	// response path back to the master
	apb_response_mux u_resp_mux (
		.psel       (psel),
		.penable    (penable),
		.psel_ch    (psel_ch),
		.prdata_ch  (prdata_ch),
		.pslverr_ch (pslverr_ch),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

endmodule

/* include/apb_master_tasks.svh */
// APB master write and read tasks for the testbench.
// Include inside the testbench module, next to clk and the APB signals.
`ifndef APB_MASTER_TASKS_SVH
`define APB_MASTER_TASKS_SVH

// one write, returns the error flag and the number of bus cycles taken
task automatic apb_write(
	input  timer_bank_pkg::paddr_t addr,
	input  timer_bank_pkg::pdata_t data,
	output logic                   err,
	output int unsigned            cycles
);
	int unsigned waits;
	waits = 0;
	@(posedge clk);
	psel    <= 1'b1;
	penable <= 1'b0;
	pwrite  <= 1'b1;
	paddr   <= addr;
	pwdata  <= data;
	@(posedge clk);
	penable <= 1'b1;
	// sample mid-cycle, away from the edge
	@(negedge clk);
	while (!pready && waits < timer_bank_pkg::APB_TIMEOUT) begin
		waits++;
		@(negedge clk);
	end
	if (!pready) begin
		$display("apb_write to %h timed out waiting for pready", addr);
	end
	err    = pslverr || !pready;
	cycles = waits + 2;
	@(posedge clk);
	psel    <= 1'b0;
	penable <= 1'b0;
endtask

// one read, returns the data, the error flag and the bus cycles taken
task automatic apb_read(
	input  timer_bank_pkg::paddr_t addr,
	output timer_bank_pkg::pdata_t data,
	output logic                   err,
	output int unsigned            cycles
);
	int unsigned waits;
	waits = 0;
	@(posedge clk);
	psel    <= 1'b1;
	penable <= 1'b0;
	pwrite  <= 1'b0;
	paddr   <= addr;
	@(posedge clk);
	penable <= 1'b1;
	@(negedge clk);
	while (!pready && waits < timer_bank_pkg::APB_TIMEOUT) begin
		waits++;
		@(negedge clk);
	end
	if (!pready) begin
		$display("apb_read from %h timed out waiting for pready", addr);
	end
	data   = prdata;
	err    = pslverr || !pready;
	cycles = waits + 2;
	@(posedge clk);
	psel    <= 1'b0;
	penable <= 1'b0;
endtask

`endif

/* sim/timer_bank_tb.sv */
// Testbench for the timer bank: APB register access, counting, compare irq and errors.
// Compile with the file list; timer_bank_tb is the top module.

`timescale 1ns/100ps

module timer_bank_tb;

	import timer_bank_pkg::*;

	localparam int COUNT_K = 8;
	localparam int IRQ_CH  = 1;
	localparam int ERR_CH  = 2;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	paddr_t    paddr;
	pdata_t    pwdata;
	pdata_t    prdata;
	logic      pready;
	logic      pslverr;
	chan_vec_t irq;

	int unsigned errors;
	int unsigned bus_errors = 0;
	int unsigned checks;
	logic        irq_at_read = 1'b0;

	// expected register contents
	pdata_t model_mtime [N_CHANNELS];
	pdata_t model_cmp [N_CHANNELS];

	timer_bank dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.irq     (irq)
	);

	always #50 clk = ~clk;

	`include "apb_master_tasks.svh"

	// --------------------------------------------------
	// helpers
	function automatic paddr_t chan_addr(input int ch, input logic [SLOT_LSB-1:0] off);
		return (paddr_t'(ch) << SLOT_LSB) | paddr_t'(off);
	endfunction

	task automatic compare_word(input string what, input pdata_t got, input pdata_t exp);
		checks++;
		assert (got === exp) else begin
			$display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic verify_flag(input string what, input logic cond);
		checks++;
		assert (cond === 1'b1) else begin
			$display("ERR %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic write_reg(input paddr_t addr, input pdata_t data);
		logic        err;
		int unsigned cycles;
		apb_write(addr, data, err, cycles);
		verify_flag($sformatf("write to %h answered with an error", addr), !err);
		verify_flag($sformatf("write to %h took %0d cycles", addr, cycles), cycles == 2);
	endtask

	task automatic read_and_compare(input paddr_t addr, input pdata_t exp, input string what);
		pdata_t      data;
		logic        err;
		int unsigned cycles;
		apb_read(addr, data, err, cycles);
		verify_flag($sformatf("read from %h answered with an error", addr), !err);
		verify_flag($sformatf("read from %h took %0d cycles", addr, cycles), cycles == 2);
		compare_word(what, data, exp);
	endtask

	// access that must come back with pslverr
	task automatic access_expect_error(input paddr_t addr, input logic do_write,
			input logic zero_data);
		pdata_t      data;
		logic        err;
		int unsigned cycles;
		data = '0;
		if (do_write) begin
			apb_write(addr, $urandom, err, cycles);
		end else begin
			apb_read(addr, data, err, cycles);
		end
		verify_flag($sformatf("access to %h gave no pslverr", addr), err);
		verify_flag($sformatf("access to %h took %0d cycles", addr, cycles), cycles == 2);
		if (zero_data && !do_write) begin
			compare_word($sformatf("data from unmapped %h", addr), data, '0);
		end
	endtask

	// --------------------------------------------------
	// monitors
	always @(negedge clk) begin
		if (!(psel && penable)) begin
			assert (!pready && !pslverr) else begin
				$display("ERR %0t: pready or pslverr high outside an access cycle", $time);
				bus_errors++;
			end
		end
	end

	// irq as seen while mtime of the irq channel is on the bus
	always @(negedge clk) begin
		if (psel && penable && !pwrite && paddr == chan_addr(IRQ_CH, REG_MTIME)) begin
			irq_at_read <= irq[IRQ_CH];
		end
	end

	initial begin
		#1_000_000;
		$display("simulation did not finish within the time limit");
		$display("test failed");
		$finish;
	end

	// --------------------------------------------------
	// stimulus
	initial begin
		pdata_t      data;
		logic        err;
		int unsigned cycles;
		int unsigned seed;
		int unsigned polls;
		int unsigned waited;
		pdata_t      cmp_small;
		logic        reached;

		seed    = $urandom(77);
		errors  = 0;
		checks  = 0;
		rst_n   <= 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// reset state
		@(negedge clk);
		compare_word("irq after reset", pdata_t'(irq), '0);
		for (int ch = 0; ch < N_CHANNELS; ch++) begin
			read_and_compare(chan_addr(ch, REG_CTRL), '0, $sformatf("ch%0d ctrl after reset", ch));
			read_and_compare(chan_addr(ch, REG_MTIME), '0, $sformatf("ch%0d mtime after reset", ch));
			read_and_compare(chan_addr(ch, REG_MTIMECMP), '1,
				$sformatf("ch%0d mtimecmp after reset", ch));
		end

		// register access, enable toggled before the counters are loaded
		for (int ch = 0; ch < N_CHANNELS; ch++) begin
			write_reg(chan_addr(ch, REG_CTRL), 32'h1);
			read_and_compare(chan_addr(ch, REG_CTRL), 32'h1, $sformatf("ch%0d ctrl enabled", ch));
			write_reg(chan_addr(ch, REG_CTRL), 32'h0);
			read_and_compare(chan_addr(ch, REG_CTRL), 32'h0, $sformatf("ch%0d ctrl disabled", ch));
			model_cmp[ch]   = $urandom;
			model_mtime[ch] = $urandom;
			write_reg(chan_addr(ch, REG_MTIMECMP), model_cmp[ch]);
			write_reg(chan_addr(ch, REG_MTIME), model_mtime[ch]);
			read_and_compare(chan_addr(ch, REG_MTIMECMP), model_cmp[ch],
				$sformatf("ch%0d mtimecmp", ch));
			read_and_compare(chan_addr(ch, REG_MTIME), model_mtime[ch], $sformatf("ch%0d mtime", ch));
		end

		// --------------------------------------------------
		// counting on channel 0
		model_mtime[0] = '0;
		write_reg(chan_addr(0, REG_MTIME), '0);
		write_reg(chan_addr(0, REG_CTRL), 32'h1);
		repeat (COUNT_K * TICK_DIV) @(posedge clk);
		write_reg(chan_addr(0, REG_CTRL), 32'h0);
		apb_read(chan_addr(0, REG_MTIME), data, err, cycles);
		verify_flag("mtime read of ch0 answered with an error", !err);
		verify_flag($sformatf("ch0 counted %0d ticks, expected %0d to %0d", data,
			COUNT_K - 1, COUNT_K + 1),
			data >= pdata_t'(COUNT_K - 1) && data <= pdata_t'(COUNT_K + 1));
		model_mtime[0] = data;
		// disabled channels hold their values
		for (int ch = 1; ch < N_CHANNELS; ch++) begin
			read_and_compare(chan_addr(ch, REG_MTIME), model_mtime[ch],
				$sformatf("ch%0d mtime while disabled", ch));
		end

		// --------------------------------------------------
		// compare interrupt
		cmp_small = pdata_t'(3 + $urandom % 6);
		write_reg(chan_addr(IRQ_CH, REG_MTIME), '0);
		write_reg(chan_addr(IRQ_CH, REG_MTIMECMP), cmp_small);
		write_reg(chan_addr(IRQ_CH, REG_CTRL), 32'h1);
		reached = 1'b0;
		polls   = 0;
		while (!reached && polls < 64) begin
			apb_read(chan_addr(IRQ_CH, REG_MTIME), data, err, cycles);
			polls++;
			verify_flag($sformatf("mtime read of ch%0d answered with an error", IRQ_CH), !err);
			verify_flag($sformatf("irq was %b with mtime %0d and mtimecmp %0d", irq_at_read,
				data, cmp_small), irq_at_read == (data >= cmp_small));
			reached = (data >= cmp_small);
		end
		if (!reached) begin
			$display("mtime of channel %0d never reached mtimecmp", IRQ_CH);
			errors++;
		end
		waited = 0;
		@(negedge clk);
		while (!irq[IRQ_CH] && waited < TICK_DIV + 2) begin
			waited++;
			@(negedge clk);
		end
		if (!irq[IRQ_CH]) begin
			$display("irq of channel %0d did not rise after mtime reached mtimecmp", IRQ_CH);
			errors++;
		end
		read_and_compare(chan_addr(IRQ_CH, REG_CTRL), 32'h3, "ctrl with irq pending");

		// raising mtimecmp or clearing enable drops irq
		write_reg(chan_addr(IRQ_CH, REG_MTIMECMP), 32'hFFFF_FF00);
		@(negedge clk);
		verify_flag("irq still high after mtimecmp was raised", !irq[IRQ_CH]);
		write_reg(chan_addr(IRQ_CH, REG_MTIMECMP), cmp_small);
		@(negedge clk);
		verify_flag("irq low with mtime at or above mtimecmp", irq[IRQ_CH]);
		write_reg(chan_addr(IRQ_CH, REG_CTRL), 32'h0);
		@(negedge clk);
		verify_flag("irq still high after enable was cleared", !irq[IRQ_CH]);
		compare_word("irq of the bank with all channels disabled", pdata_t'(irq), '0);

		// --------------------------------------------------
		// errors
		access_expect_error(chan_addr(ERR_CH, 12'h00C), 1'b1, 1'b0);
		access_expect_error(chan_addr(ERR_CH, 12'hFFC), 1'b0, 1'b0);
		read_and_compare(chan_addr(ERR_CH, REG_CTRL), '0, "ctrl after bad offset");
		read_and_compare(chan_addr(ERR_CH, REG_MTIME), model_mtime[ERR_CH], "mtime after bad offset");
		read_and_compare(chan_addr(ERR_CH, REG_MTIMECMP), model_cmp[ERR_CH],
			"mtimecmp after bad offset");
		access_expect_error(16'h4004, 1'b0, 1'b1);
		access_expect_error(16'h8008, 1'b0, 1'b1);
		access_expect_error(16'hC000, 1'b0, 1'b1);
		// these alias channel 0 if the upper bits were ignored
		access_expect_error(16'h4004, 1'b1, 1'b0);
		access_expect_error(16'h4008, 1'b1, 1'b0);
		read_and_compare(chan_addr(0, REG_MTIME), model_mtime[0], "ch0 mtime after unmapped write");
		read_and_compare(chan_addr(0, REG_MTIMECMP), model_cmp[0],
			"ch0 mtimecmp after unmapped write");

		$display("%0d checks, %0d errors, %0d bus errors", checks, errors, bus_errors);
		if (errors == 0 && bus_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* timer_bank.f */
+incdir+include
logic/timer_bank_pkg.sv
logic/tick_prescaler.sv
logic/apb_slot_decoder.sv
logic/timer_channel.sv
logic/apb_response_mux.sv
logic/timer_bank.sv
sim/timer_bank_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the timer bank testbench with Verilator and run it.
# Exits non-zero when the build or the run fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ"
verilator --binary --timing --assert -j 0 \
	--top-module timer_bank_tb \
	-Mdir "$OBJ" \
	-f timer_bank.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$OBJ/Vtimer_bank_tb" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$LOG"; then
	echo "failure reported, see $LOG"
	exit 1
fi

echo "simulation finished cleanly"
exit 0
